//--- hdl/u712RegPkg.sv
// Shared widths, register window constants and cycle FSM states for the register bridge
`default_nettype none

package u712RegPkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // CPU byte address
    localparam int CPU_ADDR_W = 32;
    // Word-wide register data path
    localparam int CPU_DATA_W = 16;
    // Word address into the 256 chip registers
    localparam int REG_ADDR_W = 8;

    ////////////////////////////////////////////////////////////
    // Register window
    ////////////////////////////////////////////////////////////

    // Custom chip registers start here
    localparam logic [CPU_ADDR_W-1:0] REG_BASE = 32'h00DF_F000;
    // 512 byte window, so address bits 8:0 are ignored in the compare
    localparam logic [CPU_ADDR_W-1:0] REG_MASK = 32'hFFFF_FE00;

    ////////////////////////////////////////////////////////////
    // Register cycle FSM
    ////////////////////////////////////////////////////////////

    // Named after the 68000 bus states they lead into
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        S1   = 3'd1,
        S2   = 3'd2,
        S4   = 3'd3,
        S5   = 3'd4
    } regState_t;

endpackage

`default_nettype wire

//--- hdl/regSpaceDecode.sv
// Checks each CPU transfer start against the register window and latches the hit's request
`timescale 1ns/100ps
`default_nettype none

module regSpaceDecode (
    input  logic                             CLK80,
    input  logic                             RESETn,
    input  logic                             tsN,
    input  logic                             rnW,
    input  logic [u712RegPkg::CPU_ADDR_W-1:0] cpuAddr,
    input  logic [u712RegPkg::CPU_DATA_W-1:0] cpuWrData,
    output logic                             regStartN,
    output logic                             regRnW,
    output logic [u712RegPkg::REG_ADDR_W-1:0] regAddr,
    output logic [u712RegPkg::CPU_DATA_W-1:0] regWrData
);

    import u712RegPkg::*;

    ////////////////////////////////////////////////////////////
    // Window compare
    ////////////////////////////////////////////////////////////

    logic windowHit;

    // Only the masked upper bits take part
    assign windowHit = !tsN && ((cpuAddr & REG_MASK) == REG_BASE);

    ////////////////////////////////////////////////////////////
    // Start strobe
    ////////////////////////////////////////////////////////////

    // One cycle low pulse, one clock after the hit
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            regStartN <= 1'b1;
        end else begin
            regStartN <= !windowHit;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request latch
    ////////////////////////////////////////////////////////////

    // Held until the next hit
    always_ff @(posedge CLK80) begin
        if (windowHit) begin
            // Byte address bit 0 dropped, word registers only
            regAddr   <= cpuAddr[REG_ADDR_W:1];
            regRnW    <= rnW;
            regWrData <= cpuWrData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regCycleSm.sv
// Builds a 68000-style chipset register cycle from a decoded start, paced by C1/C3 and DBR
`timescale 1ns/100ps
`default_nettype none

module regCycleSm (
    input  logic CLK80,
    input  logic RESETn,
    input  logic regStartN,
    input  logic regRnW,
    input  logic c1,
    input  logic c3,
    input  logic dbrN,
    output logic asN,
    output logic regEnN,
    output logic dsEn,
    output logic regCycle,
    output logic regTack
);

    import u712RegPkg::*;

    ////////////////////////////////////////////////////////////
    // Chipset clock and DBR synchronizers
    ////////////////////////////////////////////////////////////

    logic [1:0] c1Sync;
    logic [1:0] c3Sync;
    logic [1:0] dbrSync;

    // Two stages each, bit 1 is the safe copy
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            c1Sync  <= 2'b11;
            c3Sync  <= 2'b11;
            dbrSync <= 2'b11;
        end else begin
            c1Sync  <= {c1Sync[0], c1};
            c3Sync  <= {c3Sync[0], c3};
            dbrSync <= {dbrSync[0], dbrN};
        end
    end

    ////////////////////////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////////////////////////

    regState_t state;
    logic      pending;
    logic      cycleRnW;
    logic      leaveIdle;

    // Phase where a new 68000 cycle may begin
    assign leaveIdle = (state == IDLE) && pending && !c1Sync[1] && c3Sync[1];

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state    <= IDLE;
            pending  <= 1'b0;
            cycleRnW <= 1'b1;
            asN      <= 1'b1;
            regEnN   <= 1'b1;
            dsEn     <= 1'b0;
            regCycle <= 1'b0;
            regTack  <= 1'b0;
        end else begin
            // CPU may start again while the last cycle is in S5
            // a fresh start wins over the clear
            pending <= !regStartN || (pending && !leaveIdle);
            // Acknowledge is a single cycle pulse
            regTack <= 1'b0;

            unique case (state)
                IDLE: begin
                    if (leaveIdle) begin
                        // Direction frozen for the whole cycle
                        cycleRnW <= regRnW;
                        state    <= S1;
                    end
                end
                S1: begin
                    if (!c1Sync[1] && !c3Sync[1]) begin
                        // State 2, strobes out
                        asN    <= 1'b0;
                        regEnN <= 1'b0;
                        dsEn   <= cycleRnW;
                        state  <= S2;
                    end
                end
                S2: begin
                    // Wait states while the chipset owns the bus
                    if (dbrSync[1] && c1Sync[1] && c3Sync[1]) begin
                        // State 4
                        regCycle <= 1'b1;
                        dsEn     <= 1'b1;
                        state    <= S4;
                    end
                end
                S4: begin
                    if (!c1Sync[1] && c3Sync[1]) begin
                        // State 5, early read acknowledge
                        regTack <= cycleRnW;
                        state   <= S5;
                    end
                end
                S5: begin
                    if (c1Sync[1] && !c3Sync[1]) begin
                        // State 7, cycle done, late write acknowledge
                        regTack  <= !cycleRnW;
                        asN      <= 1'b1;
                        regEnN   <= 1'b1;
                        dsEn     <= 1'b0;
                        regCycle <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/regDataPath.sv
// Read capture and write drive between the CPU data bus and the chip register bus
`timescale 1ns/100ps
`default_nettype none

module regDataPath (
    input  logic                             CLK80,
    input  logic                             RESETn,
    input  logic                             regRnW,
    input  logic                             dsEn,
    input  logic                             regTack,
    input  logic [u712RegPkg::CPU_DATA_W-1:0] regWrData,
    input  logic [u712RegPkg::CPU_DATA_W-1:0] chipRdData,
    output logic [u712RegPkg::CPU_DATA_W-1:0] cpuRdData,
    output logic [u712RegPkg::CPU_DATA_W-1:0] chipWrData
);

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    logic rdCapture;

    // Acknowledge doubles as the latch strobe
    assign rdCapture = regTack && regRnW;

    // Held for the CPU until the next read lands
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            cpuRdData <= '0;
        end else if (rdCapture) begin
            cpuRdData <= chipRdData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    logic wrDrive;

    // Buffer enable, data strobe on a write
    assign wrDrive = dsEn && !regRnW;

    // Zero stands in for the released buffer
    always_comb begin
        if (wrDrive) begin
            chipWrData = regWrData;
        end else begin
            chipWrData = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/u712RegTop.sv
// Top of the register bridge, joins decoder, cycle FSM and data path to CPU and chip pins
`timescale 1ns/100ps
`default_nettype none

module u712RegTop (
    input  logic                             CLK80,
    input  logic                             RESETn,
    // CPU side
    input  logic                             tsN,
    input  logic                             rnW,
    input  logic [u712RegPkg::CPU_ADDR_W-1:0] cpuAddr,
    input  logic [u712RegPkg::CPU_DATA_W-1:0] cpuWrData,
    output logic                             regTack,
    output logic [u712RegPkg::CPU_DATA_W-1:0] cpuRdData,
    // Chipset side
    input  logic                             c1,
    input  logic                             c3,
    input  logic                             dbrN,
    input  logic [u712RegPkg::CPU_DATA_W-1:0] chipRdData,
    output logic                             asN,
    output logic                             regEnN,
    output logic                             dsEn,
    output logic                             regCycle,
    output logic [u712RegPkg::REG_ADDR_W-1:0] chipAddr,
    output logic [u712RegPkg::CPU_DATA_W-1:0] chipWrData
);

    ////////////////////////////////////////////////////////////
    // Decoded request
    ////////////////////////////////////////////////////////////

    logic                             regStartN;
    logic                             regRnW;
    logic [u712RegPkg::CPU_DATA_W-1:0] regWrData;

    // Latched word address goes straight to the chip bus
    regSpaceDecode i_regSpaceDecode (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .tsN       (tsN),
        .rnW       (rnW),
        .cpuAddr   (cpuAddr),
        .cpuWrData (cpuWrData),
        .regStartN (regStartN),
        .regRnW    (regRnW),
        .regAddr   (chipAddr),
        .regWrData (regWrData)
    );

    ////////////////////////////////////////////////////////////
    // Chipset cycle and data
    ////////////////////////////////////////////////////////////

    regCycleSm i_regCycleSm (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .regStartN (regStartN),
        .regRnW    (regRnW),
        .c1        (c1),
        .c3        (c3),
        .dbrN      (dbrN),
        .asN       (asN),
        .regEnN    (regEnN),
        .dsEn      (dsEn),
        .regCycle  (regCycle),
        .regTack   (regTack)
    );

    // Read data latched on the same acknowledge the CPU sees
    regDataPath i_regDataPath (
        .CLK80      (CLK80),
        .RESETn     (RESETn),
        .regRnW     (regRnW),
        .dsEn       (dsEn),
        .regTack    (regTack),
        .regWrData  (regWrData),
        .chipRdData (chipRdData),
        .cpuRdData  (cpuRdData),
        .chipWrData (chipWrData)
    );

endmodule

`default_nettype wire

//--- tb/u712RegTb.sv
// Testbench for the register bridge; replays tb/regTests.txt against clock, DBR and array models
`timescale 1ns/100ps
`default_nettype none

module u712RegTb;

    import u712RegPkg::*;

    localparam int QUARTER = 4;
    localparam int TIMEOUT = 200;
    localparam logic [55:0] OP_INIT    = {24'h0, "init"};
    localparam logic [55:0] OP_READ    = {24'h0, "read"};
    localparam logic [55:0] OP_WRITE   = {16'h0, "write"};
    localparam logic [55:0] OP_OUTSIDE = "outside";

    logic CLK80 = 1'b0;
    logic RESETn, tsN, rnW, c1, c3, dbrN;
    logic regTack, asN, regEnN, dsEn, regCycle;
    logic [CPU_ADDR_W-1:0] cpuAddr;
    logic [CPU_DATA_W-1:0] cpuWrData, cpuRdData, chipRdData, chipWrData;
    logic [REG_ADDR_W-1:0] chipAddr;

    // Chip register array and the expected contents
    logic [CPU_DATA_W-1:0] chipMem [0:(1<<REG_ADDR_W)-1];
    logic [CPU_DATA_W-1:0] refMem [0:(1<<REG_ADDR_W)-1];
    logic [CPU_DATA_W-1:0] prevWd;
    logic [REG_ADDR_W-1:0] prevAddr;
    logic prevAs, prevDs, prevCyc, curWrite;
    logic [31:0] lfsr = 32'h9d02_acc5;
    int qCnt, dbrLeft, curStall, tackCount, asFalls, errors, timeouts;

    always #50 CLK80 = !CLK80;

    u712RegTop i_u712RegTop (.*);

    ////////////////////////////////////////////////////////////
    // Checks and random data
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [CPU_DATA_W-1:0] lfsrWord();
        logic [CPU_DATA_W-1:0] w;
        int i;
        for (i = 0; i < CPU_DATA_W; i++) begin
            w    = {w[CPU_DATA_W-2:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // One falling edge of CLK80 with the chipset models
    ////////////////////////////////////////////////////////////

    task automatic tick();
        @(negedge CLK80);
        // Quadrature with c3 a quarter behind c1
        qCnt = (qCnt + 1) % (4 * QUARTER);
        c1   = qCnt < 2 * QUARTER;
        c3   = (qCnt >= QUARTER) && (qCnt < 3 * QUARTER);
        // Write lands as the data strobe drops
        if (prevDs && !dsEn && curWrite) chipMem[prevAddr] = prevWd;
        chipRdData = chipMem[chipAddr];
        if (regCycle && !prevCyc && !dbrN) begin
            errors++;
            $display("Error at %0t: regCycle rose while DBR was still held", $time);
        end
        // DBR low for the stall count once AS falls
        if (dbrLeft > 0) dbrLeft--;
        if (prevAs && !asN) begin
            asFalls++;
            dbrLeft = curStall;
        end
        dbrN = (dbrLeft == 0);
        if (regTack) tackCount++;
        prevAs   = asN;
        prevDs   = dsEn;
        prevCyc  = regCycle;
        prevWd   = chipWrData;
        prevAddr = chipAddr;
    endtask

    task automatic waitTack(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < TIMEOUT && !seen; n++) begin
            tick();
            seen = regTack;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout at %0t: no transfer acknowledge in %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic waitIdle();
        int n;
        for (n = 0; n < TIMEOUT && (!asN || regCycle); n++) tick();
        if (!asN || regCycle) begin
            timeouts++;
            $display("Timeout at %0t: chip bus cycle did not end in %0d cycles", $time, TIMEOUT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One line of the test file
    ////////////////////////////////////////////////////////////

    task automatic runLine(input logic [55:0] op, input logic [31:0] addr, input logic [31:0] data,
                           input int stall, input logic [31:0] expVal);
        logic seen;
        logic isRead;
        logic isWrite;
        logic [REG_ADDR_W-1:0] word;
        logic [CPU_DATA_W-1:0] wdata;
        logic [CPU_DATA_W-1:0] want;
        int tacks;
        int falls;
        int n;
        // Word offset from the window base
        word    = REG_ADDR_W'((addr - REG_BASE) >> 1);
        isRead  = (op == OP_READ);
        isWrite = (op == OP_WRITE);
        tacks   = tackCount;
        falls   = asFalls;
        if (op == OP_INIT) begin
            chipMem[word] = data[CPU_DATA_W-1:0];
            refMem[word]  = data[CPU_DATA_W-1:0];
        end else begin
            if ((addr[CPU_ADDR_W-1:9] == REG_BASE[CPU_ADDR_W-1:9]) == (op == OP_OUTSIDE)) begin
                errors++;
                $display("Error: test line address %h does not match its operation", addr);
            end
            wdata     = (isWrite && expVal[0]) ? lfsrWord() : data[CPU_DATA_W-1:0];
            tsN       = 1'b0;
            rnW       = !isWrite;
            cpuAddr   = addr;
            cpuWrData = wdata;
            curStall  = stall;
            if (op != OP_OUTSIDE) curWrite = isWrite;
            tick();
            tsN = 1'b1;
            if (op == OP_OUTSIDE) begin
                for (n = 0; n < TIMEOUT; n++) tick();
                checkValue("asN falls", 32'(asFalls - falls), 32'h0);
                checkValue("regTack pulses", 32'(tackCount - tacks), 32'h0);
            end else begin
                waitTack(seen);
                if (seen && isRead) begin
                    want = data[0] ? refMem[word] : expVal[CPU_DATA_W-1:0];
                    checkValue("chipAddr", 32'(chipAddr), 32'(word));
                    checkValue("regEnN", 32'(regEnN), 32'h0);
                    checkValue("dsEn", 32'(dsEn), 32'h1);
                    tick();
                    checkValue("cpuRdData", 32'(cpuRdData), 32'(want));
                end else if (seen) begin
                    // Late acknowledge comes with AS back up
                    checkValue("asN", 32'(asN), 32'h1);
                    refMem[word] = wdata;
                end
                if (isRead && data[1]) begin
                    // Next start goes in while still in S5
                    checkValue("regCycle", 32'(regCycle), 32'h1);
                end else begin
                    waitIdle();
                end
                checkValue("regTack pulses", 32'(tackCount - tacks), 32'h1);
                if (isWrite) checkValue("chipMem", 32'(chipMem[word]), 32'(wdata));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int fd;
        int i;
        int stall;
        logic [959:0] line;
        logic [55:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expVal;
        RESETn     = 1'b0;
        tsN        = 1'b1;
        rnW        = 1'b1;
        cpuAddr    = '0;
        cpuWrData  = '0;
        chipRdData = '0;
        c1         = 1'b1;
        c3         = 1'b0;
        dbrN       = 1'b1;
        prevAs     = 1'b1;
        prevDs     = 1'b0;
        prevCyc    = 1'b0;
        curWrite   = 1'b0;
        qCnt       = 0;
        dbrLeft    = 0;
        curStall   = 0;
        tackCount  = 0;
        asFalls    = 0;
        errors     = 0;
        timeouts   = 0;
        // Background pattern from the whole word address
        for (i = 0; i < (1 << REG_ADDR_W); i++) begin
            chipMem[i] = {8'(i) ^ 8'h5a, 8'(i)};
            refMem[i]  = chipMem[i];
        end
        repeat (5) tick();
        RESETn = 1'b1;
        tick();
        checkValue("asN", 32'(asN), 32'h1);
        checkValue("regEnN", 32'(regEnN), 32'h1);
        checkValue("dsEn", 32'(dsEn), 32'h0);
        checkValue("regCycle", 32'(regCycle), 32'h0);
        checkValue("regTack", 32'(regTack), 32'h0);
        fd = $fopen("tb/regTests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Error: could not open tb/regTests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // Comment and blank lines give fewer than five fields
                    if ($sscanf(line, "%s %h %h %d %h", op, addr, data, stall, expVal) == 5) begin
                        runLine(op, addr, data, stall, expVal);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Run finished with %0d mismatches or errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/regTests.txt
# op addr data stall exp, hex fields except the decimal stall count
# read data bit 0 means expected word from earlier writes, bit 1 means overlap next start
# write exp 1 means random data instead of the data column
init    00dff000 1234 0 0
init    00dff002 abcd 0 0
init    00dff01e 5a5a 0 0
init    00dff100 0f0f 0 0
init    00dff1fe 8001 0 0
read    00dff000 0 0 1234
read    00dff1fe 0 0 8001
write   00dff004 c3c3 0 0
read    00dff004 0 0 c3c3
write   00dff080 0 0 1
read    00dff080 1 0 0
outside 00dfe000 0 0 0
outside 00dff200 0 0 0
read    00dff002 0 0 abcd
read    00dff01e 0 12 5a5a
write   00dff040 7e7e 30 0
read    00dff040 0 5 7e7e
read    00dff100 2 0 0f0f
read    00dff002 0 0 abcd
write   00dff0fe 0 7 1
read    00dff0fe 1 0 0
read    00dff000 2 3 1234
read    00dff1fe 0 4 8001

//--- files.f
hdl/u712RegPkg.sv
hdl/regSpaceDecode.sv
hdl/regCycleSm.sv
hdl/regDataPath.sv
hdl/u712RegTop.sv
tb/u712RegTb.sv

//--- run.sh
#!/bin/sh
# Build the register bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module u712RegTb -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log
if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
